//--- renkon_defs.svh
`ifndef RENKON_DEFS_SVH
`define RENKON_DEFS_SVH

// Pixel and weight width, signed.
`define DWIDTH 16

// Image memory address width.
`define IMGSIZE 10

// Network memory address width.
`define NETSIZE 8

// Sizes and loop counters, up to 16.
`define LWIDTH 5

// Fixed point fraction bits.
`define FRAC 8
`define ACCWIDTH 40

`endif

//--- renkon_pkg.sv
`include "renkon_defs.svh"

package renkon_pkg;

  typedef logic signed [`DWIDTH-1:0]   data_t;
  typedef logic signed [`ACCWIDTH-1:0] acc_t;
  typedef logic [`IMGSIZE-1:0]         img_addr_t;
  typedef logic [`NETSIZE-1:0]         net_addr_t;
  typedef logic [`LWIDTH-1:0]          len_t;

  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_CONV    = 2'd2,
    S_DRAIN   = 2'd3
  } core_state_t;

  // Job setup, latched at req.
  typedef struct packed {
    len_t      img_size;
    len_t      fil_size;
    img_addr_t input_addr;
    img_addr_t output_addr;
    net_addr_t net_addr;
  } conv_cfg_t;

  // Framing of a tap stream.
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_bus_t;

endpackage

//--- ctrl_fsm.sv
`timescale 1ns/100ps

module ctrl_fsm (
  input  logic                    clk,
  input  logic                    xrst,
  input  logic                    req,
  input  renkon_pkg::conv_cfg_t   cfg,
  input  logic                    net_end,
  input  logic                    tap_end,
  input  logic                    conv_end,
  input  logic                    img_we,
  input  renkon_pkg::img_addr_t   img_addr,
  input  renkon_pkg::data_t       img_wdata,
  input  renkon_pkg::img_addr_t   rd_addr,
  input  renkon_pkg::data_t       result,
  input  logic                    result_valid,
  input  renkon_pkg::img_addr_t   out_addr,
  input  renkon_pkg::img_addr_t   tap_addr,
  output renkon_pkg::core_state_t state,
  output renkon_pkg::conv_cfg_t   cfg_q,
  output logic                    ack,
  output logic                    mem_we,
  output renkon_pkg::img_addr_t   mem_waddr,
  output renkon_pkg::data_t       mem_wdata,
  output renkon_pkg::img_addr_t   mem_raddr
);
  import renkon_pkg::*;

  core_state_t r_state;
  conv_cfg_t   r_cfg;
  logic        r_ack;
  logic        r_drain;
  img_addr_t   r_res_addr;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_WAIT;
      r_drain <= 1'b0;
    end else begin
      case (r_state)
        S_WAIT:
          if (req)
            r_state <= S_NETWORK;
        S_NETWORK:
          if (net_end)
            r_state <= S_CONV;
        S_CONV:
          if (conv_end)
            r_state <= S_DRAIN;
        S_DRAIN: begin
          // Two cycles for the last window to reach memory.
          r_drain <= !r_drain;
          if (r_drain)
            r_state <= S_WAIT;
        end
        default:
          r_state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_ack <= 1'b1;
    else if (req)
      r_ack <= 1'b0;
    else if (r_state == S_DRAIN && r_drain)
      r_ack <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_cfg <= '0;
    else if (r_state == S_WAIT && req)
      r_cfg <= cfg;
  end

  // Matches the result register in the MAC.
  always_ff @(posedge clk) begin
    r_res_addr <= out_addr;
  end

  assign state = r_state;
  assign cfg_q = r_cfg;
  assign ack   = r_ack;

  // Host owns both ports while idle.
  assign mem_we    = (r_state == S_WAIT) ? img_we    : result_valid;
  assign mem_waddr = (r_state == S_WAIT) ? img_addr  : r_res_addr;
  assign mem_wdata = (r_state == S_WAIT) ? img_wdata : result;
  assign mem_raddr = (r_state == S_WAIT) ? rd_addr   : tap_addr;

  assert property (@(posedge clk) disable iff (!xrst)
    req |-> r_ack);
  assert property (@(posedge clk) disable iff (!xrst)
    result_valid |-> r_state != S_WAIT);
  // Every window lands two cycles after its last tap.
  assert property (@(posedge clk) disable iff (!xrst)
    tap_end |-> ##2 result_valid);

endmodule

//--- win_counter.sv
`timescale 1ns/100ps
`include "renkon_defs.svh"

module win_counter (
  input  logic                    clk,
  input  logic                    xrst,
  input  renkon_pkg::core_state_t state,
  input  renkon_pkg::conv_cfg_t   cfg_q,
  output renkon_pkg::net_addr_t   net_raddr,
  output renkon_pkg::net_addr_t   load_idx,
  output renkon_pkg::img_addr_t   tap_addr,
  output renkon_pkg::img_addr_t   out_addr,
  output renkon_pkg::ctrl_bus_t   tap_ctrl,
  output logic                    net_end,
  output logic                    tap_end,
  output logic                    conv_end
);
  import renkon_pkg::*;

  logic [2*`LWIDTH-1:0] fil_sq;
  logic [2*`LWIDTH-1:0] r_li;
  len_t      out_size;
  len_t      r_wx;
  len_t      r_wy;
  len_t      r_ox;
  len_t      r_oy;
  logic      wx_last;
  logic      wy_last;
  logic      ox_last;
  logic      oy_last;
  ctrl_bus_t cur_ctrl;
  ctrl_bus_t r_ctrl;
  net_addr_t r_load_idx;
  img_addr_t cur_out_addr;
  img_addr_t r_out_addr;

  assign fil_sq   = cfg_q.fil_size * cfg_q.fil_size;
  assign out_size = cfg_q.img_size - cfg_q.fil_size + 1'b1;

  assign wx_last = r_wx == cfg_q.fil_size - 1'b1;
  assign wy_last = r_wy == cfg_q.fil_size - 1'b1;
  assign ox_last = r_ox == out_size - 1'b1;
  assign oy_last = r_oy == out_size - 1'b1;

  // Weights first, bias at the last index.
  always_ff @(posedge clk) begin
    if (!xrst || state != S_NETWORK)
      r_li <= '0;
    else
      r_li <= r_li + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst || state != S_CONV) begin
      r_wx <= '0;
      r_wy <= '0;
      r_ox <= '0;
      r_oy <= '0;
    end else begin
      r_wx <= wx_last ? '0 : r_wx + 1'b1;
      if (wx_last) begin
        r_wy <= wy_last ? '0 : r_wy + 1'b1;
        if (wy_last) begin
          r_ox <= ox_last ? '0 : r_ox + 1'b1;
          if (ox_last)
            r_oy <= oy_last ? '0 : r_oy + 1'b1;
        end
      end
    end
  end

  assign net_end  = state == S_NETWORK && r_li == fil_sq;
  assign tap_end  = state == S_CONV && wx_last && wy_last;
  assign conv_end = tap_end && ox_last && oy_last;

  assign net_raddr = cfg_q.net_addr + net_addr_t'(r_li);
  assign tap_addr  = cfg_q.input_addr
                   + img_addr_t'(r_oy + r_wy) * img_addr_t'(cfg_q.img_size)
                   + img_addr_t'(r_ox) + img_addr_t'(r_wx);
  assign cur_out_addr = cfg_q.output_addr
                      + img_addr_t'(r_oy) * img_addr_t'(out_size)
                      + img_addr_t'(r_ox);

  assign cur_ctrl.start = (state == S_NETWORK && r_li == '0)
                       || (state == S_CONV && r_wx == '0 && r_wy == '0);
  assign cur_ctrl.valid = state == S_NETWORK || state == S_CONV;
  assign cur_ctrl.stop  = net_end || tap_end;

  // Align with the one-cycle memory reads.
  always_ff @(posedge clk) begin
    if (!xrst)
      r_ctrl <= '0;
    else
      r_ctrl <= cur_ctrl;
  end

  always_ff @(posedge clk) begin
    r_load_idx <= net_addr_t'(r_li);
    r_out_addr <= cur_out_addr;
  end

  assign tap_ctrl = r_ctrl;
  assign load_idx = r_load_idx;
  assign out_addr = r_out_addr;

  assert property (@(posedge clk) disable iff (!xrst)
    state == S_CONV |-> r_wx < cfg_q.fil_size && r_wy < cfg_q.fil_size);

endmodule

//--- img_mem.sv
`timescale 1ns/100ps
`include "renkon_defs.svh"

module img_mem (
  input  logic                  clk,
  input  logic                  we,
  input  renkon_pkg::img_addr_t waddr,
  input  renkon_pkg::data_t     wdata,
  input  renkon_pkg::img_addr_t raddr,
  output renkon_pkg::data_t     rdata
);
  import renkon_pkg::*;

  data_t mem [0:(1<<`IMGSIZE)-1];
  data_t r_rdata;

  // Image in, results out.
  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
  end

  always_ff @(posedge clk) begin
    r_rdata <= mem[raddr];
  end

  assign rdata = r_rdata;

endmodule

//--- net_mem.sv
`timescale 1ns/100ps
`include "renkon_defs.svh"

module net_mem (
  input  logic                  clk,
  input  logic                  we,
  input  renkon_pkg::net_addr_t waddr,
  input  renkon_pkg::data_t     wdata,
  input  renkon_pkg::net_addr_t raddr,
  output renkon_pkg::data_t     rdata
);
  import renkon_pkg::*;

  // Filters with a bias after each.
  data_t mem [0:(1<<`NETSIZE)-1];
  data_t r_rdata;

  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
    r_rdata <= mem[raddr];
  end

  assign rdata = r_rdata;

endmodule

//--- conv_mac.sv
`timescale 1ns/100ps
`include "renkon_defs.svh"

module conv_mac (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  load_en,
  input  renkon_pkg::net_addr_t load_idx,
  input  renkon_pkg::data_t     net_rdata,
  input  renkon_pkg::ctrl_bus_t tap_ctrl,
  input  renkon_pkg::data_t     pix,
  output renkon_pkg::data_t     result,
  output logic                  result_valid
);
  import renkon_pkg::*;

  localparam acc_t SAT_MAX = (1 <<< (`DWIDTH-1)) - 1;
  localparam acc_t SAT_MIN = -(1 <<< (`DWIDTH-1));

  data_t     r_weight [0:(1<<`NETSIZE)-1];
  data_t     r_bias;
  net_addr_t r_tap;
  logic      r_load;
  acc_t      r_acc;
  data_t     r_result;
  logic      r_valid;
  data_t     w_sel;
  acc_t      prod;
  acc_t      acc_next;
  acc_t      sum;
  data_t     sat;

  // Stream lags the phase by one read.
  always_ff @(posedge clk) begin
    if (!xrst)
      r_load <= 1'b0;
    else
      r_load <= load_en;
  end

  always_ff @(posedge clk) begin
    if (r_load && tap_ctrl.valid) begin
      if (tap_ctrl.stop)
        r_bias <= net_rdata;
      else
        r_weight[load_idx] <= net_rdata;
    end
  end

  assign w_sel    = r_weight[tap_ctrl.start ? net_addr_t'(0) : r_tap];
  assign prod     = pix * w_sel;
  assign acc_next = (tap_ctrl.start ? acc_t'(0) : r_acc) + prod;
  assign sum      = (acc_next >>> `FRAC) + r_bias;

  always_comb begin
    if (sum > SAT_MAX)
      sat = data_t'(SAT_MAX);
    else if (sum < SAT_MIN)
      sat = data_t'(SAT_MIN);
    else
      sat = data_t'(sum);
  end

  // Tap order matches the weight layout.
  always_ff @(posedge clk) begin
    if (!xrst)
      r_tap <= '0;
    else if (!r_load && tap_ctrl.valid)
      r_tap <= tap_ctrl.start ? net_addr_t'(1) : r_tap + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!r_load && tap_ctrl.valid)
      r_acc <= acc_next;
    if (!r_load && tap_ctrl.stop)
      r_result <= sat;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_valid <= 1'b0;
    else
      r_valid <= !r_load && tap_ctrl.valid && tap_ctrl.stop;
  end

  assign result       = r_result;
  assign result_valid = r_valid;

  assert property (@(posedge clk) disable iff (!xrst)
    tap_ctrl.stop |-> tap_ctrl.valid);

endmodule

//--- renkon_top.sv
`timescale 1ns/100ps

module renkon_top (
  input  logic                    clk,
  input  logic                    xrst,
  input  logic                    req,
  input  renkon_pkg::conv_cfg_t   cfg,
  input  logic                    img_we,
  input  renkon_pkg::img_addr_t   img_addr,
  input  renkon_pkg::data_t       img_wdata,
  input  renkon_pkg::img_addr_t   rd_addr,
  output renkon_pkg::data_t       rd_data,
  input  logic                    net_we,
  input  renkon_pkg::net_addr_t   net_waddr,
  input  renkon_pkg::data_t       net_wdata,
  output logic                    ack,
  output renkon_pkg::core_state_t core_state
);
  import renkon_pkg::*;

  core_state_t state;
  conv_cfg_t   cfg_q;
  logic        net_end;
  logic        tap_end;
  logic        conv_end;
  logic        mem_we;
  img_addr_t   mem_waddr;
  data_t       mem_wdata;
  img_addr_t   mem_raddr;
  data_t       img_rdata;
  net_addr_t   net_raddr;
  data_t       net_rdata;
  net_addr_t   load_idx;
  img_addr_t   tap_addr;
  img_addr_t   out_addr;
  ctrl_bus_t   tap_ctrl;
  data_t       result;
  logic        result_valid;
  logic        load_en;

  assign load_en    = state == S_NETWORK;
  assign rd_data    = img_rdata;
  assign core_state = state;

  ctrl_fsm u_ctrl_fsm (
    .clk, .xrst, .req, .cfg, .net_end, .tap_end, .conv_end,
    .img_we, .img_addr, .img_wdata, .rd_addr, .result, .result_valid,
    .out_addr, .tap_addr, .state, .cfg_q, .ack,
    .mem_we, .mem_waddr, .mem_wdata, .mem_raddr
  );

  win_counter u_win_counter (
    .clk, .xrst, .state, .cfg_q, .net_raddr, .load_idx, .tap_addr,
    .out_addr, .tap_ctrl, .net_end, .tap_end, .conv_end
  );

  img_mem u_img_mem (
    .clk, .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
    .raddr(mem_raddr), .rdata(img_rdata)
  );

  net_mem u_net_mem (
    .clk, .we(net_we), .waddr(net_waddr), .wdata(net_wdata),
    .raddr(net_raddr), .rdata(net_rdata)
  );

  conv_mac u_conv_mac (
    .clk, .xrst, .load_en, .load_idx, .net_rdata, .tap_ctrl,
    .pix(img_rdata), .result, .result_valid
  );

endmodule

//--- tb_renkon.sv
`timescale 1ns/100ps
`include "renkon_defs.svh"

module tb_renkon;
  import renkon_pkg::*;

  localparam int NUM_ROWS = 5;
  localparam logic [1:0] PAT_IDENT = 2'd0;
  localparam logic [1:0] PAT_RAND  = 2'd1;
  localparam logic [1:0] PAT_SAT   = 2'd2;
  localparam logic [1:0] EXP_MODEL = 2'd0;
  localparam logic [1:0] EXP_COPY  = 2'd1;
  localparam logic [1:0] EXP_SAT   = 2'd2;
  localparam int SAT_HI = (1 << (`DWIDTH-1)) - 1;
  localparam int SAT_LO = -(1 << (`DWIDTH-1));

  typedef struct packed {
    conv_cfg_t  cfg;
    logic [1:0] pattern;
    logic [1:0] behavior;
  } test_row_t;

  logic        clk;
  logic        xrst;
  logic        req;
  conv_cfg_t   cfg;
  logic        img_we;
  img_addr_t   img_addr;
  data_t       img_wdata;
  img_addr_t   rd_addr;
  data_t       rd_data;
  logic        net_we;
  net_addr_t   net_waddr;
  data_t       net_wdata;
  logic        ack;
  core_state_t core_state;

  test_row_t table_rows [0:NUM_ROWS-1];
  int img_px  [0:255];
  int wts     [0:255];
  int exp_out [0:255];
  int bias;
  int cycle_cnt;
  int cycle_limit;

  renkon_top u_renkon_top (
    .clk, .xrst, .req, .cfg, .img_we, .img_addr, .img_wdata, .rd_addr, .rd_data,
    .net_we, .net_waddr, .net_wdata, .ack, .core_state
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $fatal(1);
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int idx, input int n, input int f, input int in_a,
                         input int out_a, input int net_a, input logic [1:0] pat,
                         input logic [1:0] beh);
    table_rows[idx].cfg.img_size    = len_t'(n);
    table_rows[idx].cfg.fil_size    = len_t'(f);
    table_rows[idx].cfg.input_addr  = img_addr_t'(in_a);
    table_rows[idx].cfg.output_addr = img_addr_t'(out_a);
    table_rows[idx].cfg.net_addr    = net_addr_t'(net_a);
    table_rows[idx].pattern         = pat;
    table_rows[idx].behavior        = beh;
  endtask

  // Run time plus loads and readbacks of one row.
  function automatic int row_cycles(input test_row_t r);
    int n;
    int f;
    int o;
    n = int'(r.cfg.img_size);
    f = int'(r.cfg.fil_size);
    o = n - f + 1;
    return f*f + 1 + o*o*f*f + 8 + n*n + f*f + 1 + o*o + n*n + 8;
  endfunction

  task automatic gen_data(input test_row_t r);
    int n;
    int f;
    n = int'(r.cfg.img_size);
    f = int'(r.cfg.fil_size);
    for (int y = 0; y < n; y++) begin
      for (int x = 0; x < n; x++) begin
        if (r.pattern == PAT_SAT)
          img_px[y*n+x] = (y < n/2) ? 32000 : -32000;
        else
          img_px[y*n+x] = int'($urandom % 256) - 128;
      end
    end
    for (int i = 0; i < f*f; i++) begin
      if (r.pattern == PAT_IDENT)
        wts[i] = 256;
      else if (r.pattern == PAT_SAT)
        wts[i] = 30000;
      else
        wts[i] = int'($urandom % 512) - 256;
    end
    bias = (r.pattern == PAT_RAND) ? int'($urandom % 64) - 32 : 0;
  endtask

  // Reference convolution over valid windows with stride 1.
  task automatic model(input test_row_t r);
    int n;
    int f;
    int o;
    longint acc;
    n = int'(r.cfg.img_size);
    f = int'(r.cfg.fil_size);
    o = n - f + 1;
    for (int oy = 0; oy < o; oy++) begin
      for (int ox = 0; ox < o; ox++) begin
        acc = 0;
        for (int wy = 0; wy < f; wy++)
          for (int wx = 0; wx < f; wx++)
            acc += longint'(img_px[(oy+wy)*n+ox+wx]) * longint'(wts[wy*f+wx]);
        acc = (acc >>> `FRAC) + longint'(bias);
        if (acc > SAT_HI)
          exp_out[oy*o+ox] = SAT_HI;
        else if (acc < SAT_LO)
          exp_out[oy*o+ox] = SAT_LO;
        else
          exp_out[oy*o+ox] = int'(acc);
      end
    end
  endtask

  task automatic load_memories(input test_row_t r);
    int n;
    int f;
    n = int'(r.cfg.img_size);
    f = int'(r.cfg.fil_size);
    for (int i = 0; i < n*n; i++) begin
      img_we    = 1'b1;
      img_addr  = r.cfg.input_addr + img_addr_t'(i);
      img_wdata = data_t'(img_px[i]);
      step();
    end
    img_we = 1'b0;
    // Taps row by row, then the bias.
    for (int i = 0; i <= f*f; i++) begin
      net_we    = 1'b1;
      net_waddr = r.cfg.net_addr + net_addr_t'(i);
      net_wdata = (i == f*f) ? data_t'(bias) : data_t'(wts[i]);
      step();
    end
    net_we = 1'b0;
  endtask

  task automatic read_word(input img_addr_t a, output data_t d);
    rd_addr = a;
    step();
    d = rd_data;
  endtask

  task automatic run_request(input test_row_t r, output int lat);
    cfg = r.cfg;
    req = 1'b1;
    step();
    req = 1'b0;
    check("ack", ack, 1'b0);
    check("core_state", core_state, S_NETWORK);
    lat = 1;
    while (ack !== 1'b1) begin
      step();
      lat++;
    end
    check("core_state", core_state, S_WAIT);
  endtask

  task automatic check_row(input test_row_t r);
    int n;
    int f;
    int o;
    int lat;
    data_t d;
    logic saw_hi;
    logic saw_lo;
    n = int'(r.cfg.img_size);
    f = int'(r.cfg.fil_size);
    o = n - f + 1;
    saw_hi = 1'b0;
    saw_lo = 1'b0;
    gen_data(r);
    model(r);
    load_memories(r);
    run_request(r, lat);
    check("ack_cycles_within_bound", lat <= f*f + 1 + o*o*f*f + 8, 1'b1);
    for (int i = 0; i < o*o; i++) begin
      read_word(r.cfg.output_addr + img_addr_t'(i), d);
      check($sformatf("rd_data[%0d]", int'(r.cfg.output_addr) + i), d, exp_out[i]);
      if (r.behavior == EXP_COPY)
        check($sformatf("rd_data[%0d]", int'(r.cfg.output_addr) + i), d,
              img_px[(i/o)*n + i%o]);
      if (int'(d) == SAT_HI)
        saw_hi = 1'b1;
      if (int'(d) == SAT_LO)
        saw_lo = 1'b1;
    end
    if (r.behavior == EXP_SAT) begin
      check("positive_limit_seen", saw_hi, 1'b1);
      check("negative_limit_seen", saw_lo, 1'b1);
    end
    // Source image must survive the run.
    for (int i = 0; i < n*n; i++) begin
      read_word(r.cfg.input_addr + img_addr_t'(i), d);
      check($sformatf("rd_data[%0d]", int'(r.cfg.input_addr) + i), d, img_px[i]);
    end
  endtask

  initial begin
    xrst      = 1'b0;
    req       = 1'b0;
    cfg       = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    rd_addr   = '0;
    net_we    = 1'b0;
    net_waddr = '0;
    net_wdata = '0;
    void'($urandom(32'h52d5_d22c));

    set_row(0, 5, 1, 0, 100, 0, PAT_IDENT, EXP_COPY);
    set_row(1, 8, 3, 200, 300, 16, PAT_RAND, EXP_MODEL);
    set_row(2, 6, 3, 400, 450, 40, PAT_SAT, EXP_SAT);
    set_row(3, 12, 5, 500, 700, 64, PAT_RAND, EXP_MODEL);
    set_row(4, 16, 2, 768, 0, 100, PAT_RAND, EXP_MODEL);

    cycle_limit = 8 + 16;
    for (int i = 0; i < NUM_ROWS; i++)
      cycle_limit += row_cycles(table_rows[i]);

    repeat (8) @(posedge clk);
    #1;
    xrst = 1'b1;
    check("ack", ack, 1'b1);
    check("core_state", core_state, S_WAIT);

    for (int i = 0; i < NUM_ROWS; i++)
      check_row(table_rows[i]);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
renkon_pkg.sv
ctrl_fsm.sv
win_counter.sv
img_mem.sv
net_mem.sv
conv_mac.sv
renkon_top.sv
tb_renkon.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_renkon -o tb_renkon_sim
./obj_dir/tb_renkon_sim 2>&1 | tee sim.log || true

if grep -q "Checks failed" sim.log; then
  exit 1
fi
